//--- dac_bus_pkg.sv
// Internal bus and host port types

`default_nettype none

`include "dac_regmap_cfg.svh"

package dac_bus_pkg;

  typedef enum logic {
    bus_op_read  = 1'b0,
    bus_op_write = 1'b1
  } dac_bus_op_e;

  // One host access and its answer
  typedef struct packed {
    dac_bus_op_e             op;
    logic [`DAC_ADDR_W-1:0]  addr;
    logic [31:0]             wdata;
  } dac_host_cmd_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } dac_host_rsp_t;

  // Internal bus with single-cycle valid and ack pulses
  typedef struct packed {
    logic                    valid;
    dac_bus_op_e             op;
    logic [`DAC_ADDR_W-1:0]  addr;
    logic [31:0]             wdata;
  } dac_bus_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] rdata;
  } dac_bus_rsp_t;

  typedef enum logic [1:0] {
    port_idle,
    port_issue,
    port_wait_ack,
    port_respond
  } dac_port_state_e;

endpackage

`default_nettype wire

//--- dac_channel_regs.sv
// Per-channel register block

`default_nettype none

`include "dac_regmap_cfg.svh"

module dac_channel_regs #(
  parameter int chan_index = 0
) (
  input  logic                       up_clk,
  input  logic                       up_rstn,
  input  dac_bus_pkg::dac_bus_req_t  bus_req,
  output dac_bus_pkg::dac_bus_rsp_t  bus_rsp,
  output dac_ctrl_pkg::dac_chan_cfg_t chan_cfg
);

  import dac_bus_pkg::*;
  import dac_ctrl_pkg::*;

  localparam int chan_base_i = `DAC_CHAN_BASE + chan_index * `DAC_CHAN_STRIDE;
  localparam logic [`DAC_ADDR_W-1:0] chan_base = chan_base_i[`DAC_ADDR_W-1:0];

  logic [`DAC_ADDR_W-1:0] off;
  logic                   hit;
  logic                   wr;
  logic [31:0]            rd_data;

  // Below the base the offset wraps high and misses
  assign off = bus_req.addr - chan_base;
  assign hit = off < `DAC_ADDR_W'(7);
  assign wr  = bus_req.valid && hit && (bus_req.op == bus_op_write);

  always_comb begin
    case (off[2:0])
      3'd0:    rd_data = {chan_cfg.dds_scale_2, chan_cfg.dds_scale_1};
      3'd1:    rd_data = {chan_cfg.dds_init_2, chan_cfg.dds_init_1};
      3'd2:    rd_data = {chan_cfg.dds_incr_2, chan_cfg.dds_incr_1};
      3'd3:    rd_data = {chan_cfg.pat_data_2, chan_cfg.pat_data_1};
      3'd4:    rd_data = {28'd0, chan_cfg.data_sel};
      3'd5:    rd_data = {31'd0, chan_cfg.iqcor_enb};
      3'd6:    rd_data = {chan_cfg.iqcor_coeff_2, chan_cfg.iqcor_coeff_1};
      default: rd_data = '0;
    endcase
  end

  // ********************
  // Register writes
  // ********************
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      bus_rsp  <= '0;
      chan_cfg <= '0;
    end else begin
      bus_rsp.ack   <= bus_req.valid && hit;
      bus_rsp.rdata <= (bus_req.valid && hit && bus_req.op == bus_op_read) ? rd_data : '0;
      if (wr) begin
        case (off[2:0])
          3'd0: {chan_cfg.dds_scale_2, chan_cfg.dds_scale_1} <= bus_req.wdata;
          3'd1: {chan_cfg.dds_init_2, chan_cfg.dds_init_1} <= bus_req.wdata;
          3'd2: {chan_cfg.dds_incr_2, chan_cfg.dds_incr_1} <= bus_req.wdata;
          3'd3: {chan_cfg.pat_data_2, chan_cfg.pat_data_1} <= bus_req.wdata;
          3'd4: begin
            // Illegal sources are dropped
            if (bus_req.wdata <= 32'd2) begin
              chan_cfg.data_sel <= dac_data_sel_e'(bus_req.wdata[3:0]);
            end
          end
          3'd5: chan_cfg.iqcor_enb <= bus_req.wdata[0];
          3'd6: {chan_cfg.iqcor_coeff_2, chan_cfg.iqcor_coeff_1} <= bus_req.wdata;
          default: ;
        endcase
      end
    end
  end

  data_sel_legal_a: assert property (@(posedge up_clk) disable iff (!up_rstn)
    chan_cfg.data_sel inside {sel_dds, sel_pattern, sel_zero});

endmodule

`default_nettype wire

//--- dac_common_regs.sv
// Common register block

`default_nettype none

`include "dac_regmap_cfg.svh"

module dac_common_regs (
  input  logic                         up_clk,
  input  logic                         up_rstn,
  input  dac_bus_pkg::dac_bus_req_t    bus_req,
  output dac_bus_pkg::dac_bus_rsp_t    bus_rsp,
  input  logic                         dac_dunf,
  input  logic                         dac_sync_in_status,
  output dac_ctrl_pkg::dac_common_cfg_t common_cfg
);

  import dac_bus_pkg::*;

  localparam logic [`DAC_ADDR_W-1:0] addr_version = 'h000;
  localparam logic [`DAC_ADDR_W-1:0] addr_core_id = 'h001;
  localparam logic [`DAC_ADDR_W-1:0] addr_scratch = 'h002;
  localparam logic [`DAC_ADDR_W-1:0] addr_control = 'h010;
  localparam logic [`DAC_ADDR_W-1:0] addr_status  = 'h011;
  localparam logic [`DAC_ADDR_W-1:0] addr_chans   = 'h012;

  logic [31:0] scratch;
  logic        dunf_sticky;
  logic        hit;
  logic        wr;
  logic [31:0] rd_data;

  // Address decode and readback mux
  always_comb begin
    hit     = 1'b1;
    rd_data = '0;
    case (bus_req.addr)
      addr_version: rd_data = `DAC_VERSION;
      addr_core_id: rd_data = `DAC_CORE_ID;
      addr_scratch: rd_data = scratch;
      addr_control: rd_data = {30'd0, common_cfg.dds_format, 1'b0};
      addr_status:  rd_data = {30'd0, dac_sync_in_status, dunf_sticky};
      addr_chans:   rd_data = 32'(`DAC_NUM_CHANNELS);
      default:      hit = 1'b0;
    endcase
  end

  assign wr = bus_req.valid && hit && (bus_req.op == bus_op_write);

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      bus_rsp     <= '0;
      common_cfg  <= '0;
      scratch     <= '0;
      dunf_sticky <= 1'b0;
    end else begin
      bus_rsp.ack   <= bus_req.valid && hit;
      bus_rsp.rdata <= (bus_req.valid && hit && bus_req.op == bus_op_read) ? rd_data : '0;
      // Self-clearing sync pulse that reads back as zero
      common_cfg.sync <= wr && (bus_req.addr == addr_control) && bus_req.wdata[0];
      if (wr && bus_req.addr == addr_control) begin
        common_cfg.dds_format <= bus_req.wdata[1];
      end
      if (wr && bus_req.addr == addr_scratch) begin
        scratch <= bus_req.wdata;
      end
      // A new underflow wins over the clear
      if (dac_dunf) begin
        dunf_sticky <= 1'b1;
      end else if (wr && bus_req.addr == addr_status && bus_req.wdata[0]) begin
        dunf_sticky <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- dac_ctrl_pkg.sv
// Datapath configuration types

`default_nettype none

package dac_ctrl_pkg;

  // Channel sample source
  typedef enum logic [3:0] {
    sel_dds     = 4'd0,
    sel_pattern = 4'd1,
    sel_zero    = 4'd2
  } dac_data_sel_e;

  // Per-channel settings with _1 for tone 1 and _2 for tone 2
  typedef struct packed {
    logic [15:0]   dds_scale_1;
    logic [15:0]   dds_scale_2;
    logic [15:0]   dds_init_1;
    logic [15:0]   dds_init_2;
    logic [15:0]   dds_incr_1;
    logic [15:0]   dds_incr_2;
    logic [15:0]   pat_data_1;
    logic [15:0]   pat_data_2;
    dac_data_sel_e data_sel;
    logic          iqcor_enb;
    logic [15:0]   iqcor_coeff_1;
    logic [15:0]   iqcor_coeff_2;
  } dac_chan_cfg_t;

  typedef struct packed {
    logic sync;
    logic dds_format;
  } dac_common_cfg_t;

  // Framer parameters of one JESD profile
  typedef struct packed {
    logic [7:0] m;
    logic [7:0] l;
    logic [7:0] s;
    logic [7:0] f;
    logic [7:0] n;
    logic [7:0] np;
  } dac_jesd_profile_t;

endpackage

`default_nettype wire

//--- dac_host_port.sv
// Four-phase host port

`default_nettype none

`include "dac_regmap_cfg.svh"

module dac_host_port (
  input  logic                       up_clk,
  input  logic                       up_rstn,
  input  logic                       host_req,
  input  dac_bus_pkg::dac_host_cmd_t host_cmd,
  output logic                       host_ack,
  output dac_bus_pkg::dac_host_rsp_t host_rsp,
  output dac_bus_pkg::dac_bus_req_t  bus_req,
  input  dac_bus_pkg::dac_bus_rsp_t  bus_rsp [`DAC_NUM_CHANNELS+2]
);

  import dac_bus_pkg::*;

  localparam int num_blocks = `DAC_NUM_CHANNELS + 2;
  localparam int tmo_w      = $clog2(`DAC_BUS_TIMEOUT + 1);

  dac_port_state_e         state;
  logic [tmo_w-1:0]        tmo_cnt;
  logic [num_blocks-1:0]   ack_vec;
  logic                    rsp_ack;
  logic [31:0]             rsp_rdata;

  // Merge of all block answers where idle blocks drive zero data
  always_comb begin
    rsp_rdata = '0;
    for (int i = 0; i < num_blocks; i++) begin
      ack_vec[i] = bus_rsp[i].ack;
      rsp_rdata  = rsp_rdata | bus_rsp[i].rdata;
    end
    rsp_ack = |ack_vec;
  end

  // ********************
  // Access sequencing
  // ********************
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      state         <= port_idle;
      bus_req.valid <= 1'b0;
      host_ack      <= 1'b0;
      tmo_cnt       <= '0;
    end else begin
      case (state)
        port_idle: begin
          if (host_req) begin
            bus_req.op    <= host_cmd.op;
            bus_req.addr  <= host_cmd.addr;
            bus_req.wdata <= host_cmd.wdata;
            state         <= port_issue;
          end
        end
        port_issue: begin
          bus_req.valid <= 1'b1;
          tmo_cnt       <= '0;
          state         <= port_wait_ack;
        end
        port_wait_ack: begin
          bus_req.valid <= 1'b0;
          if (rsp_ack) begin
            host_rsp.rdata <= rsp_rdata;
            host_rsp.err   <= 1'b0;
            host_ack       <= 1'b1;
            state          <= port_respond;
          end else if (tmo_cnt == tmo_w'(`DAC_BUS_TIMEOUT - 1)) begin
            // Nobody decoded the address
            host_rsp.rdata <= '0;
            host_rsp.err   <= 1'b1;
            host_ack       <= 1'b1;
            state          <= port_respond;
          end else begin
            tmo_cnt <= tmo_cnt + 1'b1;
          end
        end
        port_respond: begin
          // Hold the answer until the host lets go
          if (!host_req) begin
            host_ack <= 1'b0;
            state    <= port_idle;
          end
        end
        default: state <= port_idle;
      endcase
    end
  end

  ack_onehot_a: assert property (@(posedge up_clk) disable iff (!up_rstn)
    $onehot0(ack_vec));

  ack_needs_req_a: assert property (@(posedge up_clk) disable iff (!up_rstn)
    $rose(host_ack) |-> $past(host_req));

endmodule

`default_nettype wire

//--- dac_profile_regs.sv
// JESD framer profile registers

`default_nettype none

`include "dac_regmap_cfg.svh"

module dac_profile_regs (
  input  logic                            up_clk,
  input  logic                            up_rstn,
  input  dac_bus_pkg::dac_bus_req_t       bus_req,
  output dac_bus_pkg::dac_bus_rsp_t       bus_rsp,
  input  dac_ctrl_pkg::dac_jesd_profile_t jesd_profile [`DAC_NUM_PROFILES],
  output logic [$clog2(`DAC_NUM_PROFILES):0] profile_sel
);

  import dac_bus_pkg::*;

  localparam int sel_w = $clog2(`DAC_NUM_PROFILES) + 1;
  localparam logic [sel_w-1:0] sel_max = sel_w'(`DAC_NUM_PROFILES - 1);

  localparam logic [`DAC_ADDR_W-1:0] addr_count = `DAC_TPL_BASE;
  localparam logic [`DAC_ADDR_W-1:0] addr_sel   = `DAC_TPL_BASE + 'h01;
  localparam logic [`DAC_ADDR_W-1:0] addr_par   = `DAC_TPL_BASE + 'h10;
  localparam logic [`DAC_ADDR_W-1:0] addr_lm    = `DAC_TPL_BASE + 'h20;

  logic        hit;
  logic [31:0] rd_data;

  always_comb begin
    hit     = 1'b1;
    rd_data = '0;
    if (bus_req.addr == addr_count) begin
      rd_data = 32'(`DAC_NUM_PROFILES);
    end else if (bus_req.addr == addr_sel) begin
      rd_data = 32'(profile_sel);
    end else begin
      hit = 1'b0;
      // One word of each kind per profile
      for (int p = 0; p < `DAC_NUM_PROFILES; p++) begin
        if (bus_req.addr == addr_par + `DAC_ADDR_W'(p)) begin
          hit     = 1'b1;
          rd_data = {jesd_profile[p].np, jesd_profile[p].n,
                     jesd_profile[p].f, jesd_profile[p].s};
        end
        if (bus_req.addr == addr_lm + `DAC_ADDR_W'(p)) begin
          hit     = 1'b1;
          rd_data = {16'd0, jesd_profile[p].l, jesd_profile[p].m};
        end
      end
    end
  end

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      bus_rsp     <= '0;
      profile_sel <= '0;
    end else begin
      bus_rsp.ack   <= bus_req.valid && hit;
      bus_rsp.rdata <= (bus_req.valid && hit && bus_req.op == bus_op_read) ? rd_data : '0;
      if (bus_req.valid && bus_req.op == bus_op_write && bus_req.addr == addr_sel) begin
        // Clamp to the last supported profile
        if (bus_req.wdata >= 32'(`DAC_NUM_PROFILES)) begin
          profile_sel <= sel_max;
        end else begin
          profile_sel <= bus_req.wdata[sel_w-1:0];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- dac_regmap.sv
// DAC register map top level

`default_nettype none

`include "dac_regmap_cfg.svh"

module dac_regmap (
  input  logic                            up_clk,
  input  logic                            up_rstn,
  input  logic                            host_req,
  input  dac_bus_pkg::dac_host_cmd_t      host_cmd,
  output logic                            host_ack,
  output dac_bus_pkg::dac_host_rsp_t      host_rsp,
  input  logic                            dac_dunf,
  input  logic                            dac_sync_in_status,
  input  dac_ctrl_pkg::dac_jesd_profile_t jesd_profile [`DAC_NUM_PROFILES],
  output dac_ctrl_pkg::dac_common_cfg_t   common_cfg,
  output dac_ctrl_pkg::dac_chan_cfg_t     chan_cfg [`DAC_NUM_CHANNELS],
  output logic [$clog2(`DAC_NUM_PROFILES):0] profile_sel
);

  import dac_bus_pkg::*;

  // Slot 0 common, then channels, profile block last
  dac_bus_req_t bus_req;
  dac_bus_rsp_t blk_rsp [`DAC_NUM_CHANNELS+2];

  dac_host_port host_port_inst (
    .up_clk   (up_clk),
    .up_rstn  (up_rstn),
    .host_req (host_req),
    .host_cmd (host_cmd),
    .host_ack (host_ack),
    .host_rsp (host_rsp),
    .bus_req  (bus_req),
    .bus_rsp  (blk_rsp)
  );

  dac_common_regs common_inst (
    .up_clk             (up_clk),
    .up_rstn            (up_rstn),
    .bus_req            (bus_req),
    .bus_rsp            (blk_rsp[0]),
    .dac_dunf           (dac_dunf),
    .dac_sync_in_status (dac_sync_in_status),
    .common_cfg         (common_cfg)
  );

  for (genvar i = 0; i < `DAC_NUM_CHANNELS; i++) begin : g_channel
    dac_channel_regs #(
      .chan_index (i)
    ) chan_inst (
      .up_clk   (up_clk),
      .up_rstn  (up_rstn),
      .bus_req  (bus_req),
      .bus_rsp  (blk_rsp[i+1]),
      .chan_cfg (chan_cfg[i])
    );
  end

  dac_profile_regs profile_inst (
    .up_clk       (up_clk),
    .up_rstn      (up_rstn),
    .bus_req      (bus_req),
    .bus_rsp      (blk_rsp[`DAC_NUM_CHANNELS+1]),
    .jesd_profile (jesd_profile),
    .profile_sel  (profile_sel)
  );

endmodule

`default_nettype wire

//--- dac_regmap_cfg.svh
// DAC register map configuration

`ifndef DAC_REGMAP_CFG_SVH
`define DAC_REGMAP_CFG_SVH

// Word address width of the register space
`define DAC_ADDR_W        12

// Instance sizing
`define DAC_NUM_CHANNELS  2
`define DAC_NUM_PROFILES  2

// Read-only identification words
`define DAC_VERSION       32'h0001_0261
`define DAC_CORE_ID       32'h0000_0003

// Cycles in wait_ack before the port gives up
`define DAC_BUS_TIMEOUT   16

// Region map in words
`define DAC_TPL_BASE      12'h040
`define DAC_CHAN_BASE     12'h100
`define DAC_CHAN_STRIDE   12'h010

`endif

//--- dac_regmap_tb.sv
// DAC register map testbench

`default_nettype none

`include "dac_regmap_cfg.svh"

module dac_regmap_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import dac_bus_pkg::*;
  import dac_ctrl_pkg::*;

  localparam int sel_w       = $clog2(`DAC_NUM_PROFILES) + 1;
  localparam int ack_timeout = `DAC_BUS_TIMEOUT + 32;

  typedef enum logic [2:0] {
    k_plain,
    k_chan,
    k_common,
    k_sel,
    k_dunf,
    k_hold
  } check_kind_e;

  // One row of the stimulus table
  typedef struct packed {
    dac_bus_op_e             op;
    logic [`DAC_ADDR_W-1:0]  addr;
    logic [31:0]             wdata;
    logic [31:0]             exp_rdata;
    logic                    exp_err;
    check_kind_e             kind;
    logic                    sync_in;
  } table_entry_t;

  logic              up_clk = 1'b0;
  logic              up_rstn;
  logic              host_req;
  dac_host_cmd_t     host_cmd;
  logic              host_ack;
  dac_host_rsp_t     host_rsp;
  logic              dac_dunf;
  logic              dac_sync_in_status;
  dac_jesd_profile_t jesd_profile [`DAC_NUM_PROFILES];
  dac_common_cfg_t   common_cfg;
  dac_chan_cfg_t     chan_cfg [`DAC_NUM_CHANNELS];
  logic [sel_w-1:0]  profile_sel;

  table_entry_t      stim_table [$];
  dac_chan_cfg_t     exp_chan [`DAC_NUM_CHANNELS];
  logic              exp_format;
  logic [sel_w-1:0]  exp_sel;
  logic [31:0]       lcg_state = 32'd6;
  int                sync_pulses = 0;
  int                err_cnt = 0;
  int                tmo_cnt = 0;
  bit                aborted = 1'b0;

  always #2 up_clk = ~up_clk;

  // Sync is high between two rising edges, so one falling edge sees each pulse
  always @(negedge up_clk) begin
    if (common_cfg.sync === 1'b1) begin
      sync_pulses++;
    end
  end

  dac_regmap dac_regmap_inst (
    .up_clk             (up_clk),
    .up_rstn            (up_rstn),
    .host_req           (host_req),
    .host_cmd           (host_cmd),
    .host_ack           (host_ack),
    .host_rsp           (host_rsp),
    .dac_dunf           (dac_dunf),
    .dac_sync_in_status (dac_sync_in_status),
    .jesd_profile       (jesd_profile),
    .common_cfg         (common_cfg),
    .chan_cfg           (chan_cfg),
    .profile_sel        (profile_sel)
  );

  function automatic logic [7:0] lcg_byte();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  // ********************
  // Compare tasks
  // ********************
  task automatic check_rsp(input dac_host_rsp_t got, input dac_host_rsp_t exp,
                           input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t ns: %s response rdata %h err %b, expected rdata %h err %b",
               $time, what, got.rdata, got.err, exp.rdata, exp.err);
    end
  endtask

  task automatic check_chan(input dac_chan_cfg_t got, input dac_chan_cfg_t exp,
                            input int ch, input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t ns: %s chan_cfg[%0d] is %h, expected %h",
               $time, what, ch, got, exp);
    end
  endtask

  task automatic check_common(input dac_common_cfg_t got, input dac_common_cfg_t exp,
                              input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t ns: %s common_cfg is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_sel(input logic [sel_w-1:0] got, input logic [sel_w-1:0] exp,
                           input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t ns: %s profile_sel is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      err_cnt++;
      $display("error at %0t ns: %s saw %0d sync pulses, expected %0d", $time, what, got, exp);
    end
  endtask

  // ********************
  // Table building
  // ********************
  task automatic add_row(input dac_bus_op_e op, input logic [`DAC_ADDR_W-1:0] addr,
                         input logic [31:0] wdata, input logic [31:0] exp_rdata,
                         input logic exp_err, input check_kind_e kind, input logic sync_in);
    table_entry_t e;
    e.op        = op;
    e.addr      = addr;
    e.wdata     = wdata;
    e.exp_rdata = exp_rdata;
    e.exp_err   = exp_err;
    e.kind      = kind;
    e.sync_in   = sync_in;
    stim_table.push_back(e);
  endtask

  task automatic add_read(input logic [`DAC_ADDR_W-1:0] addr, input logic [31:0] exp_rdata,
                          input check_kind_e kind);
    add_row(bus_op_read, addr, 32'd0, exp_rdata, 1'b0, kind, 1'b0);
  endtask

  task automatic add_write(input logic [`DAC_ADDR_W-1:0] addr, input logic [31:0] wdata,
                           input check_kind_e kind);
    add_row(bus_op_write, addr, wdata, 32'd0, 1'b0, kind, 1'b0);
  endtask

  task automatic build_table();
    logic [`DAC_ADDR_W-1:0] par_addr;
    logic [`DAC_ADDR_W-1:0] lm_addr;
    add_read(12'h000, `DAC_VERSION, k_plain);
    add_read(12'h001, `DAC_CORE_ID, k_plain);
    add_read(12'h012, `DAC_NUM_CHANNELS, k_plain);
    add_write(12'h002, 32'ha5c3_0f1e, k_plain);
    add_read(12'h002, 32'ha5c3_0f1e, k_plain);
    // Channel fields with tone 1 in the low half
    add_write(12'h100, 32'h1234_5678, k_chan);
    add_read(12'h100, 32'h1234_5678, k_chan);
    add_write(12'h101, 32'h0bad_0c0d, k_chan);
    add_read(12'h101, 32'h0bad_0c0d, k_chan);
    add_write(12'h102, 32'h0001_0003, k_chan);
    add_read(12'h102, 32'h0001_0003, k_chan);
    add_write(12'h103, 32'h7f00_80ff, k_chan);
    add_write(12'h113, 32'h5555_aaaa, k_chan);
    add_read(12'h113, 32'h5555_aaaa, k_chan);
    add_read(12'h103, 32'h7f00_80ff, k_chan);
    add_write(12'h104, 32'd1, k_chan);
    add_write(12'h104, 32'd7, k_chan);
    add_read(12'h104, 32'd1, k_chan);
    add_write(12'h114, 32'd2, k_chan);
    add_read(12'h114, 32'd2, k_chan);
    add_write(12'h105, 32'd1, k_chan);
    add_read(12'h105, 32'd1, k_chan);
    add_write(12'h116, 32'hc000_4000, k_chan);
    add_read(12'h116, 32'hc000_4000, k_chan);
    // Control and sync pulse
    add_write(12'h010, 32'd3, k_common);
    add_read(12'h010, 32'd2, k_common);
    add_write(12'h010, 32'd0, k_common);
    add_write(12'h010, 32'd1, k_common);
    add_read(12'h010, 32'd0, k_common);
    // Sticky underflow and live sync_in
    add_row(bus_op_read, 12'h011, 32'd0, 32'd1, 1'b0, k_dunf, 1'b0);
    add_row(bus_op_read, 12'h011, 32'd0, 32'd3, 1'b0, k_plain, 1'b1);
    add_write(12'h011, 32'd1, k_plain);
    add_row(bus_op_read, 12'h011, 32'd0, 32'd2, 1'b0, k_plain, 1'b1);
    add_read(12'h011, 32'd0, k_plain);
    // Profiles
    add_read(`DAC_TPL_BASE, `DAC_NUM_PROFILES, k_plain);
    for (int p = 0; p < `DAC_NUM_PROFILES; p++) begin
      par_addr = `DAC_TPL_BASE + 12'h010 + p;
      lm_addr  = `DAC_TPL_BASE + 12'h020 + p;
      add_read(par_addr, {jesd_profile[p].np, jesd_profile[p].n,
                          jesd_profile[p].f, jesd_profile[p].s}, k_plain);
      add_read(lm_addr, {16'd0, jesd_profile[p].l, jesd_profile[p].m}, k_plain);
    end
    add_write(12'h041, 32'd5, k_sel);
    add_read(12'h041, `DAC_NUM_PROFILES - 1, k_sel);
    add_write(12'h041, 32'd0, k_sel);
    add_read(12'h041, 32'd0, k_sel);
    // Unmapped space answers with an error
    add_row(bus_op_read, 12'h0f0, 32'd0, 32'd0, 1'b1, k_hold, 1'b0);
    add_row(bus_op_write, 12'h0f0, 32'h1111_2222, 32'd0, 1'b1, k_hold, 1'b0);
  endtask

  // Expected register state after a write
  task automatic update_model(input table_entry_t e);
    int ch;
    int off;
    if (e.op == bus_op_write) begin
      if (e.addr == 12'h010) begin
        exp_format = e.wdata[1];
      end
      if (e.addr == `DAC_TPL_BASE + 12'h001) begin
        exp_sel = (e.wdata >= `DAC_NUM_PROFILES) ? sel_w'(`DAC_NUM_PROFILES - 1)
                                                 : e.wdata[sel_w-1:0];
      end
      if (e.addr >= `DAC_CHAN_BASE &&
          e.addr < `DAC_CHAN_BASE + `DAC_NUM_CHANNELS * `DAC_CHAN_STRIDE) begin
        ch  = (e.addr - `DAC_CHAN_BASE) / `DAC_CHAN_STRIDE;
        off = (e.addr - `DAC_CHAN_BASE) % `DAC_CHAN_STRIDE;
        case (off)
          0: {exp_chan[ch].dds_scale_2, exp_chan[ch].dds_scale_1} = e.wdata;
          1: {exp_chan[ch].dds_init_2, exp_chan[ch].dds_init_1} = e.wdata;
          2: {exp_chan[ch].dds_incr_2, exp_chan[ch].dds_incr_1} = e.wdata;
          3: {exp_chan[ch].pat_data_2, exp_chan[ch].pat_data_1} = e.wdata;
          4: begin
            if (e.wdata <= 32'd2) begin
              exp_chan[ch].data_sel = dac_data_sel_e'(e.wdata[3:0]);
            end
          end
          5: exp_chan[ch].iqcor_enb = e.wdata[0];
          6: {exp_chan[ch].iqcor_coeff_2, exp_chan[ch].iqcor_coeff_1} = e.wdata;
          default: ;
        endcase
      end
    end
  endtask

  task automatic pulse_dunf();
    @(negedge up_clk);
    dac_dunf = 1'b1;
    @(negedge up_clk);
    dac_dunf = 1'b0;
  endtask

  // ********************
  // Four-phase access
  // ********************
  task automatic run_access(input table_entry_t e, input string what,
                            output dac_host_rsp_t rsp);
    int            cycles;
    dac_host_rsp_t hold_exp;
    rsp            = '0;
    cycles         = 0;
    hold_exp.rdata = e.exp_rdata;
    hold_exp.err   = e.exp_err;
    @(negedge up_clk);
    dac_sync_in_status = e.sync_in;
    host_cmd.op        = e.op;
    host_cmd.addr      = e.addr;
    host_cmd.wdata     = e.wdata;
    host_req           = 1'b1;
    while (host_ack !== 1'b1 && cycles < ack_timeout) begin
      @(negedge up_clk);
      cycles++;
    end
    if (host_ack !== 1'b1) begin
      tmo_cnt++;
      aborted = 1'b1;
      $display("Timeout: host_ack never rose for %s", what);
    end else begin
      rsp = host_rsp;
      if (e.kind == k_hold) begin
        // Answer must stay put while the host keeps req high
        repeat (5) begin
          @(negedge up_clk);
          if (host_ack !== 1'b1) begin
            err_cnt++;
            $display("error at %0t ns: %s host_ack dropped while host_req held",
                     $time, what);
          end
          check_rsp(host_rsp, hold_exp, what);
        end
      end
      host_req = 1'b0;
      cycles   = 0;
      while (host_ack !== 1'b0 && cycles < ack_timeout) begin
        @(negedge up_clk);
        cycles++;
      end
      if (host_ack !== 1'b0) begin
        tmo_cnt++;
        aborted = 1'b1;
        $display("Timeout: host_ack never fell for %s", what);
      end
    end
  endtask

  initial begin
    table_entry_t    e;
    dac_host_rsp_t   got;
    dac_host_rsp_t   exp_rsp;
    dac_common_cfg_t exp_common;
    int              sync_before;
    string           what;
    up_rstn            = 1'b0;
    host_req           = 1'b0;
    host_cmd           = '0;
    dac_dunf           = 1'b0;
    dac_sync_in_status = 1'b0;
    foreach (jesd_profile[p]) begin
      jesd_profile[p].m  = lcg_byte();
      jesd_profile[p].l  = lcg_byte();
      jesd_profile[p].s  = lcg_byte();
      jesd_profile[p].f  = lcg_byte();
      jesd_profile[p].n  = lcg_byte();
      jesd_profile[p].np = lcg_byte();
    end
    foreach (exp_chan[ch]) begin
      exp_chan[ch] = '0;
    end
    exp_format = 1'b0;
    exp_sel    = '0;
    exp_common = '0;
    build_table();
    repeat (4) @(negedge up_clk);
    up_rstn = 1'b1;
    // Everything idle and zero out of reset
    if (host_ack !== 1'b0) begin
      err_cnt++;
      $display("error at %0t ns: host_ack is high after reset", $time);
    end
    check_common(common_cfg, exp_common, "reset");
    check_sel(profile_sel, exp_sel, "reset");
    foreach (chan_cfg[ch]) begin
      check_chan(chan_cfg[ch], exp_chan[ch], ch, "reset");
    end
    foreach (stim_table[i]) begin
      if (!aborted) begin
        e    = stim_table[i];
        what = $sformatf("row %0d", i);
        if (e.kind == k_dunf) begin
          pulse_dunf();
        end
        sync_before = sync_pulses;
        run_access(e, what, got);
        if (!aborted) begin
          update_model(e);
          exp_rsp.rdata = e.exp_rdata;
          exp_rsp.err   = e.exp_err;
          check_rsp(got, exp_rsp, what);
          case (e.kind)
            k_chan: begin
              foreach (chan_cfg[ch]) begin
                check_chan(chan_cfg[ch], exp_chan[ch], ch, what);
              end
            end
            k_common: begin
              repeat (2) @(negedge up_clk);
              check_count(sync_pulses - sync_before,
                          (e.op == bus_op_write && e.addr == 12'h010 && e.wdata[0]) ? 1 : 0,
                          what);
              exp_common.sync       = 1'b0;
              exp_common.dds_format = exp_format;
              check_common(common_cfg, exp_common, what);
            end
            k_sel: check_sel(profile_sel, exp_sel, what);
            default: ;
          endcase
        end
      end
    end
    $display("Summary: %0d errors, %0d timeouts", err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
dac_bus_pkg.sv
dac_ctrl_pkg.sv
dac_host_port.sv
dac_common_regs.sv
dac_channel_regs.sv
dac_profile_regs.sv
dac_regmap.sv
dac_regmap_tb.sv
